//--- Makefile
# Verilator build and regression run of the dot-product unit

VERILATOR ?= verilator
TOP       ?= tcu_fedp_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the regression, log in $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Regression passed" $(LOG); then echo "FAIL: run did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim.f
+incdir+source
source/tcu_pkg.sv
source/tcu_mul_f16.sv
source/tcu_align.sv
source/tcu_accum.sv
source/tcu_normalize.sv
source/tcu_fedp_ctrl.sv
source/tcu_fedp_top.sv
verif/tcu_fedp_assert.sv
verif/tcu_fedp_tb.sv

//--- source/tcu_accum.sv
// Second pipeline stage, exact sum of the aligned terms and merge of lane exceptions
`include "tcu_config.svh"

module tcu_accum (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  advance,
    input  tcu_pkg::tcu_fix_t [`TCU_LANES-1:0]    term,
    input  tcu_pkg::fedp_excep_t [`TCU_LANES-1:0] excep,
    output tcu_pkg::tcu_fix_t                     sum,
    output tcu_pkg::fedp_excep_t                  excep_sum
);

    tcu_pkg::tcu_fix_t [`TCU_LANES/2-1:0] pair;
    tcu_pkg::tcu_fix_t                    sum_d;
    tcu_pkg::fedp_excep_t                 merged;
    logic                                 any_nan;
    logic                                 pos_inf;
    logic                                 neg_inf;

    // Two-level adder tree, wide enough that no carry is lost
    always_comb begin
        for (int j = 0; j < `TCU_LANES / 2; j++) begin
            pair[j] = term[2*j] + term[2*j+1];
        end
        sum_d = '0;
        for (int j = 0; j < `TCU_LANES / 2; j++) begin
            sum_d = sum_d + pair[j];
        end
    end

    always_comb begin
        any_nan = 1'b0;
        pos_inf = 1'b0;
        neg_inf = 1'b0;
        for (int i = 0; i < `TCU_LANES; i++) begin
            any_nan = any_nan | excep[i].is_nan;
            pos_inf = pos_inf | (excep[i].is_inf & ~excep[i].sign);
            neg_inf = neg_inf | (excep[i].is_inf & excep[i].sign);
        end
        // Infinities of both signs cancel into NaN
        merged.is_nan = any_nan | (pos_inf & neg_inf);
        merged.is_inf = (pos_inf | neg_inf) & ~merged.is_nan;
        merged.sign   = neg_inf;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum       <= '0;
            excep_sum <= '0;
        end else if (advance) begin
            sum       <= sum_d;
            excep_sum <= merged;
        end
    end

endmodule

//--- source/tcu_align.sv
// First pipeline stage, places each lane product into the signed fixed-point word
`include "tcu_config.svh"

module tcu_align (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  issue,
    input  tcu_pkg::tcu_prod_t [`TCU_LANES-1:0]   prod,
    output tcu_pkg::tcu_fix_t [`TCU_LANES-1:0]    term,
    output tcu_pkg::fedp_excep_t [`TCU_LANES-1:0] excep
);

    localparam int FIX_W = `TCU_FIX_W;

    tcu_pkg::tcu_fix_t [`TCU_LANES-1:0] term_d;
    logic [`TCU_LANES-1:0][FIX_W-1:0]   mag;

    always_comb begin
        for (int i = 0; i < `TCU_LANES; i++) begin
            mag[i] = {{(FIX_W-22){1'b0}}, prod[i].sig} << prod[i].shift;
            // Special lanes are resolved through the exception flags only
            if (prod[i].excep.is_nan || prod[i].excep.is_inf) begin
                term_d[i] = '0;
            end else if (prod[i].sign) begin
                term_d[i] = -mag[i];
            end else begin
                term_d[i] = mag[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            term  <= '0;
            excep <= '0;
        end else if (issue) begin
            term <= term_d;
            for (int i = 0; i < `TCU_LANES; i++) begin
                excep[i] <= prod[i].excep;
            end
        end
    end

endmodule

//--- source/tcu_config.svh
// Build-time parameters of the FP16 dot-product unit, included by every file that sizes logic
`ifndef TCU_CONFIG_SVH
`define TCU_CONFIG_SVH

// Operand layout
`define TCU_WORDS 2
`define TCU_LANES 4

// Datapath widths
`define TCU_FIX_W 84
`define TCU_EXP_W 6

// Flow control
`define TCU_IN_DEPTH 2
`define TCU_OUT_CREDITS 4

// Request tag
`define TCU_TAG_W 8

`endif

//--- source/tcu_fedp_ctrl.sv
// Control of the dot-product unit, input queue, credit counting, issue and valid/tag pipeline
`include "tcu_config.svh"

module tcu_fedp_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  tcu_pkg::tcu_req_t      in_req,
    output logic                   in_credit,
    input  logic                   out_credit,
    output logic                   issue,
    output tcu_pkg::tcu_req_t      issue_req,
    output logic [1:0]             stage_valid,
    output logic                   out_valid,
    output logic [`TCU_TAG_W-1:0]  out_tag
);

    localparam int DEPTH = `TCU_IN_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int CRD_W = $clog2(`TCU_OUT_CREDITS + 1);

    tcu_pkg::tcu_req_t     q_mem [DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      q_count;
    logic [CRD_W-1:0]      out_crd;
    logic                  v_align;
    logic                  v_accum;
    logic [`TCU_TAG_W-1:0] tag_align;
    logic [`TCU_TAG_W-1:0] tag_accum;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // ----------------------------------------------------------
    // Issue decision
    // ----------------------------------------------------------
    // Head leaves only against a held output credit
    assign issue       = (q_count != '0) && (out_crd != '0);
    assign in_credit   = issue;
    assign issue_req   = q_mem[rd_ptr];
    assign stage_valid = {v_accum, v_align};

    always_ff @(posedge clk) begin
        if (in_valid) begin
            q_mem[wr_ptr] <= in_req;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q_count <= '0;
            out_crd <= CRD_W'(`TCU_OUT_CREDITS);
        end else begin
            if (in_valid) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (issue) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            q_count <= q_count + CNT_W'(in_valid) - CNT_W'(issue);
            out_crd <= out_crd - CRD_W'(issue) + CRD_W'(out_credit);
        end
    end

    // ----------------------------------------------------------
    // Valid and tag alongside align, accum and normalize
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v_align   <= 1'b0;
            v_accum   <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            v_align   <= issue;
            v_accum   <= v_align;
            out_valid <= v_accum;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            tag_align <= issue_req.tag;
        end
        if (v_align) begin
            tag_accum <= tag_align;
        end
        if (v_accum) begin
            out_tag <= tag_accum;
        end
    end

endmodule

//--- source/tcu_fedp_top.sv
// Top level of the FP16 dot-product unit, wires control to the multiply, align, sum and pack stages
`include "tcu_config.svh"

module tcu_fedp_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  tcu_pkg::tcu_req_t in_req,
    output logic              in_credit,
    output logic              out_valid,
    output tcu_pkg::tcu_rsp_t out_rsp,
    input  logic              out_credit
);

    logic                                  issue;
    tcu_pkg::tcu_req_t                     issue_req;
    logic [1:0]                            stage_valid;
    logic [`TCU_TAG_W-1:0]                 out_tag;
    tcu_pkg::tcu_prod_t [`TCU_LANES-1:0]   prod;
    tcu_pkg::tcu_fix_t [`TCU_LANES-1:0]    term;
    tcu_pkg::fedp_excep_t [`TCU_LANES-1:0] lane_excep;
    tcu_pkg::tcu_fix_t                     sum;
    tcu_pkg::fedp_excep_t                  excep_sum;
    logic [31:0]                           result;

    tcu_fedp_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_req      (in_req),
        .in_credit   (in_credit),
        .out_credit  (out_credit),
        .issue       (issue),
        .issue_req   (issue_req),
        .stage_valid (stage_valid),
        .out_valid   (out_valid),
        .out_tag     (out_tag)
    );

    tcu_mul_f16 u_mul (
        .a_row (issue_req.a_row),
        .b_col (issue_req.b_col),
        .prod  (prod)
    );

    tcu_align u_align (
        .clk   (clk),
        .rst_n (rst_n),
        .issue (issue),
        .prod  (prod),
        .term  (term),
        .excep (lane_excep)
    );

    tcu_accum u_accum (
        .clk       (clk),
        .rst_n     (rst_n),
        .advance   (stage_valid[0]),
        .term      (term),
        .excep     (lane_excep),
        .sum       (sum),
        .excep_sum (excep_sum)
    );

    tcu_normalize u_normalize (
        .clk       (clk),
        .rst_n     (rst_n),
        .advance   (stage_valid[1]),
        .sum       (sum),
        .excep_sum (excep_sum),
        .result    (result)
    );

    assign out_rsp = {result, out_tag};

endmodule

//--- source/tcu_mul_f16.sv
// Combinational FP16 lane multiplier, turns raw operand words into per-lane products for alignment
`include "tcu_config.svh"

module tcu_mul_f16 (
    input  logic [`TCU_WORDS-1:0][31:0]         a_row,
    input  logic [`TCU_WORDS-1:0][31:0]         b_col,
    output tcu_pkg::tcu_prod_t [`TCU_LANES-1:0] prod
);

    localparam int EXP_W = `TCU_EXP_W;
    localparam logic [4:0] EXP_MAX = 5'h1F;
    // Both FP16 biases folded with the 2^-48 fixed-point offset
    localparam logic [EXP_W-1:0] BIAS_CONST = EXP_W'(-2);

    function automatic tcu_pkg::fedp_class_t classify(input logic [4:0] e, input logic [9:0] m);
        tcu_pkg::fedp_class_t c;
        c.is_zero = (e == 5'd0) && (m == 10'd0);
        c.is_sub  = (e == 5'd0) && (m != 10'd0);
        c.is_inf  = (e == EXP_MAX) && (m == 10'd0);
        c.is_nan  = (e == EXP_MAX) && (m != 10'd0);
        return c;
    endfunction

    for (genvar i = 0; i < `TCU_LANES; i++) begin : g_lane
        localparam int OFF = (i % 2) * 16;

        // ----------------------------------------------------------
        // Field extraction and classification
        // ----------------------------------------------------------
        logic [4:0]           ea;
        logic [4:0]           eb;
        logic [9:0]           ma;
        logic [9:0]           mb;
        tcu_pkg::fedp_class_t cls_a;
        tcu_pkg::fedp_class_t cls_b;

        assign ea    = a_row[i/2][14+OFF -: 5];
        assign eb    = b_col[i/2][14+OFF -: 5];
        assign ma    = a_row[i/2][9+OFF -: 10];
        assign mb    = b_col[i/2][9+OFF -: 10];
        assign cls_a = classify(ea, ma);
        assign cls_b = classify(eb, mb);

        // ----------------------------------------------------------
        // Arithmetic
        // ----------------------------------------------------------
        logic [4:0]       ea_sel;
        logic [4:0]       eb_sel;
        logic [10:0]      ma_sel;
        logic [10:0]      mb_sel;
        logic [EXP_W-1:0] shift;
        logic [21:0]      man_prod;
        logic             zero_sel;
        logic             inf_z;

        // Subnormals use exponent 1 and no hidden bit
        assign ea_sel   = cls_a.is_sub ? 5'd1 : ea;
        assign eb_sel   = cls_b.is_sub ? 5'd1 : eb;
        assign ma_sel   = {~cls_a.is_sub, ma};
        assign mb_sel   = {~cls_b.is_sub, mb};
        assign shift    = EXP_W'(ea_sel) + EXP_W'(eb_sel) + BIAS_CONST;
        assign man_prod = ma_sel * mb_sel;
        assign zero_sel = cls_a.is_zero | cls_b.is_zero;
        assign inf_z    = (cls_a.is_inf & cls_b.is_zero) | (cls_a.is_zero & cls_b.is_inf);

        assign prod[i].sign         = a_row[i/2][15+OFF] ^ b_col[i/2][15+OFF];
        assign prod[i].sig          = zero_sel ? 22'd0 : man_prod;
        assign prod[i].shift        = zero_sel ? '0 : shift;
        assign prod[i].excep.is_nan = cls_a.is_nan | cls_b.is_nan | inf_z;
        assign prod[i].excep.is_inf = (cls_a.is_inf | cls_b.is_inf) & ~inf_z;
        assign prod[i].excep.sign   = prod[i].sign;
    end

endmodule

//--- source/tcu_normalize.sv
// Last pipeline stage, packs the exact fixed-point sum into FP32 with truncation
`include "tcu_config.svh"

module tcu_normalize (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 advance,
    input  tcu_pkg::tcu_fix_t    sum,
    input  tcu_pkg::fedp_excep_t excep_sum,
    output logic [31:0]          result
);

    localparam int FIX_W = `TCU_FIX_W;
    localparam int POS_W = $clog2(FIX_W);
    // FP32 bias minus the fixed-point fraction width
    localparam logic [7:0] EXP_OFFSET = 8'(127 - 48);

    logic [FIX_W-1:0] mag;
    logic [POS_W-1:0] lead;
    logic [FIX_W-1:0] norm;
    logic [7:0]       exp_f;
    logic [31:0]      result_d;

    assign mag = sum[FIX_W-1] ? -sum : sum;

    // ----------------------------------------------------------
    // Leading-one search, highest set bit wins
    // ----------------------------------------------------------
    always_comb begin
        lead = '0;
        for (int b = 0; b < FIX_W; b++) begin
            if (mag[b]) begin
                lead = POS_W'(b);
            end
        end
    end

    assign norm  = mag << (POS_W'(FIX_W - 1) - lead);
    assign exp_f = 8'(lead) + EXP_OFFSET;

    // ----------------------------------------------------------
    // Packing and special encodings
    // ----------------------------------------------------------
    always_comb begin
        if (excep_sum.is_nan) begin
            result_d = 32'h7FC0_0000;
        end else if (excep_sum.is_inf) begin
            result_d = {excep_sum.sign, 8'hFF, 23'd0};
        end else if (mag == '0) begin
            // Exact cancellation gives +0
            result_d = 32'd0;
        end else begin
            result_d = {sum[FIX_W-1], exp_f, norm[FIX_W-2 -: 23]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else if (advance) begin
            result <= result_d;
        end
    end

endmodule

//--- source/tcu_pkg.sv
// Shared types of the dot-product unit, referenced by scoped name from the RTL and testbench
`include "tcu_config.svh"

package tcu_pkg;

    // Operand class from the exponent and mantissa fields
    typedef struct packed {
        logic is_zero;
        logic is_sub;
        logic is_inf;
        logic is_nan;
    } fedp_class_t;

    // Special-value flags carried beside a product or a sum
    typedef struct packed {
        logic is_nan;
        logic is_inf;
        logic sign;
    } fedp_excep_t;

    // One lane product, value is sig * 2^(shift - 48)
    typedef struct packed {
        logic                  sign;
        logic [21:0]           sig;
        logic [`TCU_EXP_W-1:0] shift;
        fedp_excep_t           excep;
    } tcu_prod_t;

    // Signed fixed point, LSB weight 2^-48
    typedef logic signed [`TCU_FIX_W-1:0] tcu_fix_t;

    typedef struct packed {
        logic [`TCU_WORDS-1:0][31:0] a_row;
        logic [`TCU_WORDS-1:0][31:0] b_col;
        logic [`TCU_TAG_W-1:0]       tag;
    } tcu_req_t;

    typedef struct packed {
        logic [31:0]           result;
        logic [`TCU_TAG_W-1:0] tag;
    } tcu_rsp_t;

endpackage

//--- verif/tcu_fedp_assert.sv
// Protocol checks on the control block, bound into every tcu_fedp_ctrl instance
`include "tcu_config.svh"

module tcu_fedp_assert (
    input logic                                    clk,
    input logic                                    rst_n,
    input logic                                    in_valid,
    input logic                                    in_credit,
    input logic                                    issue,
    input logic                                    out_valid,
    input logic                                    out_credit,
    input logic [$clog2(`TCU_IN_DEPTH + 1)-1:0]    q_count,
    input logic [$clog2(`TCU_OUT_CREDITS + 1)-1:0] out_crd
);

    localparam int HELD_W = $clog2(`TCU_OUT_CREDITS + 1) + 1;

    // Results sent and not yet credited back by the receiver
    logic [HELD_W-1:0] held;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held <= '0;
        end else begin
            held <= held + HELD_W'(out_valid) - HELD_W'(out_credit);
        end
    end

    // ------------------------------------------------------------
    // Input queue
    // ------------------------------------------------------------
    a_queue_bound: assert property (@(posedge clk) disable iff (!rst_n)
        q_count <= `TCU_IN_DEPTH)
        else $error("input queue holds more entries than its depth");

    // Write into a full queue without a pop
    a_queue_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        (in_valid && !issue) |-> (q_count < `TCU_IN_DEPTH))
        else $error("request written into a full input queue");

    // ------------------------------------------------------------
    // Output credits
    // ------------------------------------------------------------
    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        out_crd <= `TCU_OUT_CREDITS)
        else $error("output credit count above its initial value");

    a_valid_credit: assert property (@(posedge clk) disable iff (!rst_n)
        held <= HELD_W'(`TCU_OUT_CREDITS))
        else $error("result sent with no output credit held");

    a_reset_credit: assert property (@(posedge clk)
        $rose(rst_n) |-> !in_credit)
        else $error("input credit pulse right after reset");

endmodule

bind tcu_fedp_ctrl tcu_fedp_assert u_ctrl_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_credit  (in_credit),
    .issue      (issue),
    .out_valid  (out_valid),
    .out_credit (out_credit),
    .q_count    (q_count),
    .out_crd    (out_crd)
);

//--- verif/tcu_fedp_tb.sv
// Self-checking testbench of the FP16 dot-product unit, run as the simulation top with the file list
`include "tcu_config.svh"

module tcu_fedp_tb;

    localparam int SEED       = 32'h98a8_ac60;
    localparam int IN_DEPTH   = `TCU_IN_DEPTH;
    localparam int TOTAL_REQS = 8 + 200 + 8 + 10 + 12;
    localparam int MAX_CYCLES = TOTAL_REQS * 20 + 500;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              in_valid = 1'b0;
    tcu_pkg::tcu_req_t in_req = '0;
    logic              in_credit;
    logic              out_valid;
    tcu_pkg::tcu_rsp_t out_rsp;
    logic              out_credit = 1'b0;

    tcu_pkg::tcu_req_t pend_q[$];
    tcu_pkg::tcu_rsp_t exp_q[$];
    tcu_pkg::tcu_rsp_t exp_rsp;
    logic [7:0]        next_tag = 8'd0;
    logic              hold_credits = 1'b0;
    int                sent_count = 0;
    int                credits_returned = 0;
    int                credits_given = 0;
    int                rx_count = 0;
    int                cmp_errors = 0;
    int                test_errors = 0;
    int                cycle_count = 0;
    int                rx_mark = 0;
    int                err_mark = 0;
    int                rx_before = 0;
    int                crd_before = 0;

    tcu_fedp_top u_tcu_fedp_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_rsp    (out_rsp),
        .out_credit (out_credit)
    );

    always #2 clk = ~clk;

    // ------------------------------------------------------------
    // Reference model, exact sum with LSB 2^-48
    // ------------------------------------------------------------
    function automatic logic nan_operand(input logic [15:0] h);
        return (h[14:10] == 5'h1F) && (h[9:0] != 10'd0);
    endfunction

    function automatic logic inf_operand(input logic [15:0] h);
        return (h[14:10] == 5'h1F) && (h[9:0] == 10'd0);
    endfunction

    // Hidden bit only for normal numbers
    function automatic logic [10:0] significand(input logic [15:0] h);
        return {h[14:10] != 5'd0, h[9:0]};
    endfunction

    function automatic int scale_exp(input logic [15:0] h);
        return (h[14:10] == 5'd0) ? 1 : int'(h[14:10]);
    endfunction

    function automatic logic [31:0] expected_result(input tcu_pkg::tcu_req_t req);
        logic [3:0][15:0]   ha;
        logic [3:0][15:0]   hb;
        logic signed [95:0] acc;
        logic [95:0]        lane_mag;
        logic [95:0]        mag;
        logic [95:0]        mant;
        logic               nan_seen;
        logic               pos_inf;
        logic               neg_inf;
        logic               neg;
        int                 lead;
        ha       = req.a_row;
        hb       = req.b_col;
        acc      = '0;
        nan_seen = 1'b0;
        pos_inf  = 1'b0;
        neg_inf  = 1'b0;
        for (int i = 0; i < `TCU_LANES; i++) begin
            neg = ha[i][15] ^ hb[i][15];
            if (nan_operand(ha[i]) || nan_operand(hb[i])) begin
                nan_seen = 1'b1;
            end else if (inf_operand(ha[i]) || inf_operand(hb[i])) begin
                // Infinity times zero
                if (ha[i][14:0] == 15'd0 || hb[i][14:0] == 15'd0) begin
                    nan_seen = 1'b1;
                end else if (neg) begin
                    neg_inf = 1'b1;
                end else begin
                    pos_inf = 1'b1;
                end
            end else begin
                lane_mag = 96'(significand(ha[i])) * 96'(significand(hb[i]));
                lane_mag = lane_mag << (scale_exp(ha[i]) + scale_exp(hb[i]) - 2);
                acc = neg ? acc - lane_mag : acc + lane_mag;
            end
        end
        if (nan_seen || (pos_inf && neg_inf)) begin
            return 32'h7FC0_0000;
        end
        if (pos_inf || neg_inf) begin
            return {neg_inf, 8'hFF, 23'd0};
        end
        if (acc == '0) begin
            return 32'd0;
        end
        mag  = acc[95] ? 96'(-acc) : 96'(acc);
        lead = 0;
        for (int b = 0; b < 96; b++) begin
            if (mag[b]) begin
                lead = b;
            end
        end
        // 23 bits below the leading one, the rest dropped
        mant = (lead >= 23) ? (mag >> (lead - 23)) : (mag << (23 - lead));
        return {acc[95], 8'(79 + lead), mant[22:0]};
    endfunction

    // ------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------
    function automatic logic [15:0] random_half();
        logic [4:0] e;
        if ($urandom_range(0, 3) == 0) begin
            e = 5'd0;
        end else begin
            e = 5'($urandom_range(1, 30));
        end
        return {1'($urandom_range(0, 1)), e, 10'($urandom())};
    endfunction

    task automatic queue_request(input logic [31:0] a0, input logic [31:0] a1,
                                 input logic [31:0] b0, input logic [31:0] b1);
        tcu_pkg::tcu_req_t req;
        tcu_pkg::tcu_rsp_t rsp;
        req.a_row[0] = a0;
        req.a_row[1] = a1;
        req.b_col[0] = b0;
        req.b_col[1] = b1;
        req.tag      = next_tag;
        rsp.result   = expected_result(req);
        rsp.tag      = next_tag;
        next_tag     = next_tag + 8'd1;
        pend_q.push_back(req);
        exp_q.push_back(rsp);
    endtask

    task automatic queue_random();
        queue_request({random_half(), random_half()}, {random_half(), random_half()},
                      {random_half(), random_half()}, {random_half(), random_half()});
    endtask

    function automatic int error_total();
        return cmp_errors + test_errors;
    endfunction

    task automatic wait_idle();
        while (sent_count < pend_q.size() || rx_count < exp_q.size() ||
               credits_given < rx_count) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic report_test(input string name);
        $display("Test %s: %0d responses, %0d errors", name, rx_count - rx_mark,
                 error_total() - err_mark);
        rx_mark  = rx_count;
        err_mark = error_total();
    endtask

    // ------------------------------------------------------------
    // Sender, receiver and comparison
    // ------------------------------------------------------------
    // Sender holds IN_DEPTH - sent + returned credits
    always @(posedge clk) begin
        #1;
        if (rst_n && sent_count < pend_q.size() &&
            (IN_DEPTH - sent_count + credits_returned) > 0) begin
            in_req     = pend_q[sent_count];
            in_valid   = 1'b1;
            sent_count = sent_count + 1;
        end else begin
            in_valid = 1'b0;
        end
    end

    always @(negedge clk) begin
        if (rst_n && in_credit) begin
            credits_returned = credits_returned + 1;
        end
    end

    // One output credit back per consumed result unless held
    always @(posedge clk) begin
        #1;
        if (!hold_credits && credits_given < rx_count) begin
            out_credit    = 1'b1;
            credits_given = credits_given + 1;
        end else begin
            out_credit = 1'b0;
        end
    end

    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            if (rx_count < exp_q.size()) begin
                exp_rsp = exp_q[rx_count];
                assert (out_rsp.result == exp_rsp.result) else begin
                    $display("Mismatch out_rsp.result: expected %h, got %h (tag %h)",
                             exp_rsp.result, out_rsp.result, exp_rsp.tag);
                    cmp_errors = cmp_errors + 1;
                end
                assert (out_rsp.tag == exp_rsp.tag) else begin
                    $display("Mismatch out_rsp.tag: expected %h, got %h",
                             exp_rsp.tag, out_rsp.tag);
                    cmp_errors = cmp_errors + 1;
                end
            end else begin
                $display("Error: a response with tag %h came with no request outstanding",
                         out_rsp.tag);
                cmp_errors = cmp_errors + 1;
            end
            rx_count = rx_count + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Error: run stopped after %0d cycles with %0d of %0d responses received",
                     cycle_count, rx_count, exp_q.size());
            $display("Regression failed");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        void'($urandom(SEED));
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;
        @(posedge clk);

        // Ones, small integers, mixed signs, cancellation, subnormals, zeros
        queue_request(32'h3C00_3C00, 32'h3C00_3C00, 32'h3C00_3C00, 32'h3C00_3C00);
        queue_request(32'h4200_4000, 32'h4000_3C00, 32'h4000_4200, 32'h3C00_4400);
        queue_request(32'h3C00_BC00, 32'h4000_C000, 32'h3C00_3C00, 32'h3C00_3C00);
        queue_request(32'hC200_3800, 32'hBC00_4500, 32'h3800_4000, 32'h4600_C000);
        queue_request(32'h0001_0001, 32'h0001_0001, 32'h0001_0001, 32'h0001_0001);
        queue_request(32'h7BFF_7BFF, 32'h7BFF_7BFF, 32'h7BFF_7BFF, 32'h7BFF_7BFF);
        queue_request(32'h3C00_0000, 32'h4000_8000, 32'h0000_4000, 32'h8000_3C00);
        queue_request(32'h2E66_3555, 32'h3A00_B4CD, 32'hC123_3C01, 32'h0200_4567);
        wait_idle();
        report_test("directed");

        repeat (200) queue_random();
        wait_idle();
        report_test("random");

        // Infinities, NaN operands and infinity times zero
        queue_request(32'h7C00_3C00, 32'h3C00_3C00, 32'h3C00_3C00, 32'h3C00_3C00);
        queue_request(32'h3C00_FC00, 32'h0000_0000, 32'h4000_4000, 32'h0000_0000);
        queue_request(32'h3C00_7C00, 32'h0000_0000, 32'h3C00_0000, 32'h0000_0000);
        queue_request(32'h7E00_3C00, 32'h3C00_3C00, 32'h3C00_3C00, 32'h3C00_3C00);
        queue_request(32'h7C00_7C00, 32'h0000_0000, 32'hBC00_3C00, 32'h0000_0000);
        queue_request(32'h7BFF_7C00, 32'h7BFF_7BFF, 32'h7BFF_4000, 32'hFBFF_7BFF);
        queue_request(32'h3C00_0000, 32'h0000_0000, 32'h3C00_7D00, 32'h0000_0000);
        queue_request(32'hFC00_7C00, 32'h0000_0000, 32'h3C00_BC00, 32'h0000_0000);
        wait_idle();
        report_test("special");

        // Receiver withholds credits for a while
        hold_credits = 1'b1;
        rx_before    = rx_count;
        repeat (10) queue_random();
        repeat (40) @(posedge clk);
        assert (rx_count - rx_before <= `TCU_OUT_CREDITS) else begin
            $display("Error: %0d results came out while only %0d output credits were held",
                     rx_count - rx_before, `TCU_OUT_CREDITS);
            test_errors = test_errors + 1;
        end
        hold_credits = 1'b0;
        wait_idle();
        report_test("backpressure");

        crd_before = credits_returned;
        repeat (12) queue_random();
        wait_idle();
        assert (credits_returned - crd_before == 12 &&
                IN_DEPTH - sent_count + credits_returned == IN_DEPTH) else begin
            $display("Error: sender holds %0d input credits when idle, expected %0d",
                     IN_DEPTH - sent_count + credits_returned, IN_DEPTH);
            test_errors = test_errors + 1;
        end
        report_test("input credits");

        $display("Summary: %0d responses checked, %0d errors", rx_count, error_total());
        if (error_total() == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
